// File: Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f verilog.f --top-module ldqTb

run: build
	@out=$$(./obj_dir/VldqTb); echo "$$out"; echo "$$out" | grep -qx "Verification passed"

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module ldqTb

clean:
	rm -rf obj_dir

// File: hw/ldqAlloc.sv
`timescale 1ns/1ns
`default_nettype none

module ldqAlloc (
  input wire logic clk,
  input wire logic rst,
  input wire logic newEn,
  input wire ldqPkg::ldqEntryMask_t freeVec,
  input wire logic retired,
  output ldqPkg::ldqEntryMask_t allocVec,
  output logic doStall
);
  import ldqPkg::*;

  ldqEntryMask_t firstFree;
  logic accept;
  logic allocated;
  logic [COUNT_WIDTH-1:0] count;

  // isolate lowest set bit
  assign firstFree = freeVec & (~freeVec + ldqEntryMask_t'(1));

  assign accept = newEn && !doStall;
  assign allocVec = accept ? firstFree : '0;
  assign allocated = |allocVec;

  assign doStall = count >= COUNT_WIDTH'(STALL_LEVEL);

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else begin
      case ({allocated, retired})
        2'b10: count <= count + COUNT_WIDTH'(1);
        2'b01: count <= count - COUNT_WIDTH'(1);
        // both or neither leave the count alone
        default: count <= count;
      endcase
    end
  end

  // stall threshold must always leave a free entry for an accepted load
  assert property (@(posedge clk) disable iff (rst)
    accept |-> freeVec != '0)
  else $error("ldqAlloc: load accepted with no free entry");

  assert property (@(posedge clk) disable iff (rst)
    count <= COUNT_WIDTH'(NUM_ENTRIES))
  else $error("ldqAlloc: occupancy %0d above queue size", count);

endmodule

`default_nettype wire

// File: hw/ldqArray.sv
`timescale 1ns/1ns
`default_nettype none

module ldqArray (
  input wire logic clk,
  input wire logic rst,
  input wire ldqPkg::ldqEntryMask_t allocVec,
  input wire ldqPkg::ldqLoad_t newLoad,
  input wire logic stEn,
  input wire ldqPkg::ldqStore_t stReq,
  input wire ldqPkg::ldqEntryMask_t retireVec,
  output ldqPkg::ldqEntryView_t [ldqPkg::NUM_ENTRIES-1:0] entryView,
  output ldqPkg::ldqEntryMask_t freeVec
);
  import ldqPkg::*;

  // probe and load are shared, strobes are per entry
  for (genvar i = 0; i < NUM_ENTRIES; i++) begin : gEntry
    ldqEntry u_ldqEntry (
      .clk(clk),
      .rst(rst),
      .alloc(allocVec[i]),
      .newLoad(newLoad),
      .stEn(stEn),
      .stReq(stReq),
      .retire(retireVec[i]),
      .view(entryView[i])
    );
  end

  always_comb begin
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      freeVec[i] = ~entryView[i].valid;
    end
  end

endmodule

`default_nettype wire

// File: hw/ldqEntry.sv
`timescale 1ns/1ns
`default_nettype none

module ldqEntry (
  input wire logic clk,
  input wire logic rst,
  input wire logic alloc,
  input wire ldqPkg::ldqLoad_t newLoad,
  input wire logic stEn,
  input wire ldqPkg::ldqStore_t stReq,
  input wire logic retire,
  output ldqPkg::ldqEntryView_t view
);
  import ldqPkg::*;

  logic valid;
  logic confl;
  ldqLineAddr_t lineAddr;
  ldqBanks_t banks;
  ldqIi_t ii;

  ldqLineAddr_t cmpAddr;
  ldqBanks_t cmpBanks;
  logic stHit;

  // incoming load is compared while it is being written
  assign cmpAddr = alloc ? newLoad.lineAddr : lineAddr;
  assign cmpBanks = alloc ? newLoad.banks : banks;

  assign stHit = stEn && (valid || alloc) && cmpAddr == stReq.lineAddr &&
                 |(cmpBanks & stReq.banks);

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
      confl <= 1'b0;
    end else if (alloc) begin
      valid <= 1'b1;
      confl <= stHit;
    end else begin
      if (retire) begin
        valid <= 1'b0;
      end
      // sticky until the slot is reused
      confl <= confl | stHit;
    end
  end

  always_ff @(posedge clk) begin
    if (alloc) begin
      lineAddr <= newLoad.lineAddr;
      banks <= newLoad.banks;
      ii <= newLoad.ii;
    end
  end

  assign view.valid = valid;
  assign view.ii = ii;
  assign view.confl = confl | stHit;

  assert property (@(posedge clk) disable iff (rst) !(alloc && valid))
  else $error("ldqEntry: allocation into an occupied entry");

endmodule

`default_nettype wire

// File: hw/ldqPkg.sv
`default_nettype none

package ldqPkg;

  // queue geometry
  localparam int NUM_ENTRIES = 8;
  localparam int ENTRY_IDX_WIDTH = 3;

  // load and store fields
  localparam int LINE_ADDR_WIDTH = 36;
  localparam int BANK_COUNT = 32;
  localparam int II_WIDTH = 10;

  // occupancy tracking
  localparam int COUNT_WIDTH = 4;
  localparam int STALL_LEVEL = 6;

  typedef logic [LINE_ADDR_WIDTH-1:0] ldqLineAddr_t;
  typedef logic [BANK_COUNT-1:0] ldqBanks_t;
  typedef logic [II_WIDTH-1:0] ldqIi_t;
  typedef logic [NUM_ENTRIES-1:0] ldqEntryMask_t;

  typedef struct packed {
    ldqLineAddr_t lineAddr;
    ldqBanks_t banks;
    ldqIi_t ii;
  } ldqLoad_t;

  typedef struct packed {
    ldqLineAddr_t lineAddr;
    ldqBanks_t banks;
  } ldqStore_t;

  // confl already folds in this cycle's store hit
  typedef struct packed {
    logic valid;
    ldqIi_t ii;
    logic confl;
  } ldqEntryView_t;

  typedef enum logic [1:0] {
    RET_CLEAN = 2'd0,
    RET_CONFL = 2'd1,
    RET_MISS = 2'd2
  } ldqRetCode_t;

endpackage

`default_nettype wire

// File: hw/ldqRetire.sv
`timescale 1ns/1ns
`default_nettype none

module ldqRetire (
  input wire logic clk,
  input wire logic rst,
  input wire logic retEn,
  input wire ldqPkg::ldqIi_t retIi,
  input wire ldqPkg::ldqEntryView_t [ldqPkg::NUM_ENTRIES-1:0] entryView,
  output ldqPkg::ldqEntryMask_t retireVec,
  output logic retired,
  output logic retDone,
  output ldqPkg::ldqRetCode_t retResult
);
  import ldqPkg::*;

  ldqEntryMask_t hitVec;
  logic [ENTRY_IDX_WIDTH-1:0] hitIdx;
  logic hitConfl;

  // II compare against every held load
  always_comb begin
    hitVec = '0;
    hitIdx = '0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (entryView[i].valid && entryView[i].ii == retIi) begin
        hitVec[i] = 1'b1;
        hitIdx = ENTRY_IDX_WIDTH'(i);
      end
    end
  end

  assign retireVec = retEn ? hitVec : '0;
  assign retired = |retireVec;
  assign hitConfl = entryView[hitIdx].confl;

  always_ff @(posedge clk) begin
    if (rst) begin
      retDone <= 1'b0;
    end else begin
      retDone <= retEn;
    end
  end

  always_ff @(posedge clk) begin
    if (!retired) begin
      retResult <= RET_MISS;
    end else begin
      retResult <= hitConfl ? RET_CONFL : RET_CLEAN;
    end
  end

  // IIs issued upstream are unique among held loads
  assert property (@(posedge clk) disable iff (rst) $onehot0(hitVec))
  else $error("ldqRetire: II %0h held by more than one entry", retIi);

endmodule

`default_nettype wire

// File: hw/ldqTop.sv
`timescale 1ns/1ns
`default_nettype none

module ldqTop (
  input wire logic clk,
  input wire logic rst,
  input wire logic newEn,
  input wire ldqPkg::ldqLoad_t newLoad,
  output logic doStall,
  input wire logic stEn,
  input wire ldqPkg::ldqStore_t stReq,
  input wire logic retEn,
  input wire ldqPkg::ldqIi_t retIi,
  output logic retDone,
  output ldqPkg::ldqRetCode_t retResult
);
  import ldqPkg::*;

  ldqEntryMask_t freeVec;
  ldqEntryMask_t allocVec;
  ldqEntryMask_t retireVec;
  ldqEntryView_t [NUM_ENTRIES-1:0] entryView;
  logic retired;

  ldqAlloc u_ldqAlloc (
    .clk(clk),
    .rst(rst),
    .newEn(newEn),
    .freeVec(freeVec),
    .retired(retired),
    .allocVec(allocVec),
    .doStall(doStall)
  );

  ldqArray u_ldqArray (
    .clk(clk),
    .rst(rst),
    .allocVec(allocVec),
    .newLoad(newLoad),
    .stEn(stEn),
    .stReq(stReq),
    .retireVec(retireVec),
    .entryView(entryView),
    .freeVec(freeVec)
  );

  ldqRetire u_ldqRetire (
    .clk(clk),
    .rst(rst),
    .retEn(retEn),
    .retIi(retIi),
    .entryView(entryView),
    .retireVec(retireVec),
    .retired(retired),
    .retDone(retDone),
    .retResult(retResult)
  );

endmodule

`default_nettype wire

// File: test/ldqTb.sv
`timescale 1ns/1ns
`default_nettype none

module ldqTb;
  import ldqPkg::*;

  logic clk;
  logic rst;
  logic newEn;
  ldqLoad_t newLoad;
  logic doStall;
  logic stEn;
  ldqStore_t stReq;
  logic retEn;
  ldqIi_t retIi;
  logic retDone;
  ldqRetCode_t retResult;

  // reference model of the queue
  logic mValid [NUM_ENTRIES];
  logic mConfl [NUM_ENTRIES];
  ldqLineAddr_t mAddr [NUM_ENTRIES];
  ldqBanks_t mBanks [NUM_ENTRIES];
  ldqIi_t mIi [NUM_ENTRIES];
  int expCount = 0;
  logic expDone = 1'b0;
  ldqRetCode_t expResult = RET_MISS;

  logic [15:0] lfsr = 16'd78;
  ldqIi_t nextIi = 10'd1;
  int errCount = 0;
  int nClean = 0;
  int nConfl = 0;
  int nMiss = 0;
  int nStall = 0;

  ldqTop u_ldqTop (
    .clk(clk),
    .rst(rst),
    .newEn(newEn),
    .newLoad(newLoad),
    .doStall(doStall),
    .stEn(stEn),
    .stReq(stReq),
    .retEn(retEn),
    .retIi(retIi),
    .retDone(retDone),
    .retResult(retResult)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  assert property (@(posedge clk) disable iff (rst) retDone == expDone)
  else begin
    errCount++;
    $display("Fail retDone: got %h, expected %h", $sampled(retDone), $sampled(expDone));
  end

  assert property (@(posedge clk) disable iff (rst) retDone |-> retResult == expResult)
  else begin
    errCount++;
    $display("Fail retResult: got %h, expected %h", $sampled(retResult), $sampled(expResult));
  end

  assert property (@(posedge clk) disable iff (rst) doStall == (expCount >= STALL_LEVEL))
  else begin
    errCount++;
    $display("Fail doStall: got %h, expected %h (occupancy %h)", $sampled(doStall),
             $sampled(expCount >= STALL_LEVEL), $sampled(expCount));
  end

  // galois lfsr, one step per bit
  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] r;
    int k;
    r = '0;
    for (k = 0; k < n; k++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return r;
  endfunction

  // small pool of lines so probes hit often
  function automatic ldqLineAddr_t addrOf(input logic [1:0] sel);
    return {34'h0ABCD000, sel};
  endfunction

  function automatic ldqLineAddr_t randAddr();
    logic [31:0] r;
    r = takeBits(2);
    return addrOf(r[1:0]);
  endfunction

  function automatic ldqBanks_t randBanks();
    logic [31:0] low;
    logic [31:0] pos;
    low = takeBits(3);
    pos = takeBits(2);
    return ldqBanks_t'(low << (pos * 8));
  endfunction

  function automatic logic storeHits(input ldqLineAddr_t a, input ldqBanks_t b);
    return stEn && a == stReq.lineAddr && (b & stReq.banks) != '0;
  endfunction

  // applies the inputs sampled at this edge
  function automatic void modelStep();
    int i;
    int slot;
    int hitIdx;
    logic accepted;
    slot = -1;
    hitIdx = -1;
    if (rst) begin
      for (i = 0; i < NUM_ENTRIES; i++) begin
        mValid[i] = 1'b0;
        mConfl[i] = 1'b0;
      end
      expCount = 0;
      expDone = 1'b0;
    end else begin
      accepted = newEn && expCount < STALL_LEVEL;
      for (i = NUM_ENTRIES - 1; i >= 0; i--) begin
        if (!mValid[i]) slot = i;
      end
      for (i = 0; i < NUM_ENTRIES; i++) begin
        if (retEn && mValid[i] && mIi[i] == retIi) hitIdx = i;
      end
      expDone = retEn;
      if (hitIdx >= 0 && (mConfl[hitIdx] || storeHits(mAddr[hitIdx], mBanks[hitIdx]))) begin
        expResult = RET_CONFL;
      end else if (hitIdx >= 0) begin
        expResult = RET_CLEAN;
      end else begin
        expResult = RET_MISS;
      end
      for (i = 0; i < NUM_ENTRIES; i++) begin
        if (mValid[i] && storeHits(mAddr[i], mBanks[i])) mConfl[i] = 1'b1;
      end
      if (hitIdx >= 0) mValid[hitIdx] = 1'b0;
      if (accepted && slot >= 0) begin
        mValid[slot] = 1'b1;
        mAddr[slot] = newLoad.lineAddr;
        mBanks[slot] = newLoad.banks;
        mIi[slot] = newLoad.ii;
        mConfl[slot] = storeHits(newLoad.lineAddr, newLoad.banks);
      end
      expCount = expCount + (accepted ? 1 : 0) - (hitIdx >= 0 ? 1 : 0);
      if (retEn && expResult == RET_CONFL) nConfl++;
      if (retEn && expResult == RET_CLEAN) nClean++;
      if (retEn && expResult == RET_MISS) nMiss++;
      if (expCount >= STALL_LEVEL) nStall++;
    end
  endfunction

  // one clock, strobes fall back to idle
  task automatic tick();
    @(posedge clk);
    modelStep();
    newEn <= 1'b0;
    stEn <= 1'b0;
    retEn <= 1'b0;
  endtask

  task automatic allocLoad(input ldqLineAddr_t a, input ldqBanks_t b);
    newEn <= 1'b1;
    newLoad <= '{lineAddr: a, banks: b, ii: nextIi};
    nextIi = nextIi + 10'd1;
  endtask

  task automatic probe(input ldqLineAddr_t a, input ldqBanks_t b);
    stEn <= 1'b1;
    stReq <= '{lineAddr: a, banks: b};
  endtask

  task automatic retireIi(input ldqIi_t ii);
    retEn <= 1'b1;
    retIi <= ii;
  endtask

  task automatic waitDone();
    int n;
    logic seen;
    seen = 1'b0;
    for (n = 0; n < 20 && !seen; n++) begin
      tick();
      @(negedge clk);
      seen = retDone;
    end
    if (!seen) begin
      errCount++;
      $display("retDone did not rise within 20 cycles of a retire");
    end
  endtask

  initial begin
    int c;
    int i;
    int idx;
    logic [31:0] r;
    ldqIi_t base;
    rst <= 1'b1;
    newEn <= 1'b0;
    newLoad <= '0;
    stEn <= 1'b0;
    stReq <= '0;
    retEn <= 1'b0;
    retIi <= '0;
    repeat (4) tick();
    rst <= 1'b0;

    // empty queue
    tick();
    retireIi(10'h3f);
    waitDone();

    base = nextIi;
    tick();
    allocLoad(addrOf(2'd0), 32'h0000_0003);
    probe(addrOf(2'd0), 32'h0000_0002);
    tick();
    allocLoad(addrOf(2'd0), 32'h0000_0030);
    probe(addrOf(2'd0), 32'h0000_0300);
    tick();
    allocLoad(addrOf(2'd1), 32'h0003_0000);
    probe(addrOf(2'd2), 32'h0003_0000);
    tick();
    allocLoad(addrOf(2'd2), 32'h0100_0000);
    tick();
    probe(addrOf(2'd1), 32'h0001_0000);
    tick();
    probe(addrOf(2'd2), 32'h0200_0000);
    tick();
    retireIi(base);
    waitDone();
    // hit in the retire cycle itself
    tick();
    retireIi(base + 10'd1);
    probe(addrOf(2'd0), 32'h0000_0010);
    waitDone();
    tick();
    retireIi(base + 10'd2);
    waitDone();
    tick();
    retireIi(base + 10'd3);
    waitDone();
    tick();
    retireIi(base + 10'd3);
    waitDone();

    // random mix, stays out of stall by the model count
    for (c = 0; c < 800; c++) begin
      tick();
      if (takeBits(1) == 32'd1 && expCount < STALL_LEVEL) allocLoad(randAddr(), randBanks());
      if (takeBits(1) == 32'd1) probe(randAddr(), randBanks());
      if (takeBits(1) == 32'd1) begin
        idx = int'(takeBits(3));
        r = takeBits(10);
        retireIi(mValid[idx] ? mIi[idx] : r[9:0]);
      end
    end

    // drain
    for (i = 0; i < NUM_ENTRIES; i++) begin
      tick();
      if (mValid[i]) retireIi(mIi[i]);
    end
    repeat (3) tick();

    if (nConfl == 0 || nClean == 0 || nMiss == 0 || nStall == 0) begin
      errCount++;
      $display("stimulus did not reach every retire outcome and the stall level");
    end
    $display("errors %0d, clean %0d, conflict %0d, miss %0d, stall cycles %0d",
             errCount, nClean, nConfl, nMiss, nStall);
    if (errCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
hw/ldqPkg.sv
hw/ldqAlloc.sv
hw/ldqEntry.sv
hw/ldqArray.sv
hw/ldqRetire.sv
hw/ldqTop.sv
test/ldqTb.sv
